/* design/apb_fifo_regs.sv */
`timescale 1ns/1ps

module apb_fifo_regs import fifo_asym_pkg::*; (
   input  logic                clk,
   input  logic                rst,

   // apb slave port
   input  apb_req_t            req,
   output apb_rsp_t            rsp,

   // fifo write side
   output logic                push,
   output logic [w_data_w-1:0] push_data,
   input  logic                full,
   input  status_t             status
);

   logic setup_q;
   logic access;

   logic hit_data;
   logic hit_status;

   logic wr_data;
   logic rd_data;
   logic wr_status;
   logic rd_status;
   logic unmapped;
   logic overflow;

   // remember a setup cycle so that a held penable cannot push twice
   always_ff @(posedge clk) begin
      if (rst) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= req.psel & ~req.penable;
      end
   end

   assign access = req.psel & req.penable & setup_q;

   // address decode
   assign hit_data   = (req.paddr == reg_data);
   assign hit_status = (req.paddr == reg_status);

   assign wr_data   = access &  req.pwrite & hit_data;
   assign rd_data   = access & ~req.pwrite & hit_data;
   assign wr_status = access &  req.pwrite & hit_status;
   assign rd_status = access & ~req.pwrite & hit_status;
   assign unmapped  = access & ~hit_data & ~hit_status;

   // word is dropped when there is no room
   assign overflow = wr_data & full;

   assign push      = wr_data & ~full;
   assign push_data = req.pwdata;

   always_comb begin
      rsp.pready = 1'b1;
      rsp.prdata = '0;
      if (rd_status) begin
         rsp.prdata = status;
      end
      // DATA is write only and STATUS read only
      rsp.pslverr = overflow | rd_data | wr_status | unmapped;
   end

endmodule

/* design/byte_stream_out.sv */
`timescale 1ns/1ps

module byte_stream_out import fifo_asym_pkg::*; (
   input  logic                clk,
   input  logic                rst,

   // fifo read side
   output logic                pop,
   input  logic                empty,
   input  logic [r_data_w-1:0] rd_byte,

   // byte stream
   output byte_stream_t        tx,
   input  logic                ready
);

   // two entry holding buffer, slot 0 is the oldest
   logic [r_data_w-1:0] buf_q [2];
   logic [1:0]          count;
   logic                inflight;

   logic       fire;
   logic [1:0] occ_next;
   logic [1:0] slot;

   assign fire = (count != 2'd0) & ready;

   // bytes held after this cycle, counting the read in flight
   assign occ_next = count + {1'b0, inflight} - {1'b0, fire};
   assign pop      = ~empty & (occ_next < 2'd2);

   // where an arriving byte lands once the outgoing one has left
   assign slot = count - {1'b0, fire};

   always_ff @(posedge clk) begin
      if (rst) begin
         count    <= '0;
         inflight <= 1'b0;
      end else begin
         count    <= occ_next;
         inflight <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         buf_q[0] <= buf_q[1];
      end
      // ram data is valid the cycle after the pop
      if (inflight) begin
         if (slot == 2'd0) begin
            buf_q[0] <= rd_byte;
         end else begin
            buf_q[1] <= rd_byte;
         end
      end
   end

   assign tx.valid = (count != 2'd0);
   assign tx.data  = buf_q[0];

endmodule

/* design/fifo_asym_pkg.sv */
package fifo_asym_pkg;

   // write side is one word, read side is one byte
   localparam int w_data_w   = 32;
   localparam int r_data_w   = 8;
   localparam int ratio_log2 = 2;

   // 16 words on the write side
   localparam int w_addr_w  = 4;
   localparam int r_addr_w  = w_addr_w + ratio_log2;

   // one extra bit so a full fifo can show its level
   localparam int w_level_w = w_addr_w + 1;
   localparam int r_level_w = r_addr_w + 1;

   // register map
   localparam int apb_addr_w = 8;
   localparam logic [apb_addr_w-1:0] reg_data   = 8'h00;
   localparam logic [apb_addr_w-1:0] reg_status = 8'h04;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [apb_addr_w-1:0] paddr;
      logic [w_data_w-1:0]   pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [w_data_w-1:0] prdata;
      logic                pready;
      logic                pslverr;
   } apb_rsp_t;

   // status word as seen at the STATUS register
   typedef struct packed {
      logic [w_data_w-r_level_w-w_level_w-3:0] rsvd;
      logic                                    full;
      logic                                    empty;
      logic [r_level_w-1:0]                    r_level;
      logic [w_level_w-1:0]                    w_level;
   } status_t;

   // ready travels beside this as a single bit
   typedef struct packed {
      logic                valid;
      logic [r_data_w-1:0] data;
   } byte_stream_t;

endpackage

/* design/fifo_asym_top.sv */
`timescale 1ns/1ps

module fifo_asym_top import fifo_asym_pkg::*; (
   input  logic         clk,
   input  logic         rst,

   // host side
   input  apb_req_t     apb_req,
   output apb_rsp_t     apb_rsp,

   // consumer side
   output byte_stream_t tx,
   input  logic         tx_ready
);

   // regs to fifo
   logic                push;
   logic [w_data_w-1:0] push_data;
   logic                full;
   status_t             status;

   // fifo to output stage
   logic                pop;
   logic                empty;
   logic [r_data_w-1:0] rd_byte;

   apb_fifo_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .req       (apb_req),
      .rsp       (apb_rsp),
      .push      (push),
      .push_data (push_data),
      .full      (full),
      .status    (status)
   );

   fifo_sync_asym u_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_data (push_data),
      .full      (full),
      .pop       (pop),
      .empty     (empty),
      .rd_byte   (rd_byte),
      .status    (status)
   );

   byte_stream_out u_out (
      .clk     (clk),
      .rst     (rst),
      .pop     (pop),
      .empty   (empty),
      .rd_byte (rd_byte),
      .tx      (tx),
      .ready   (tx_ready)
   );

endmodule

/* design/fifo_sync_asym.sv */
`timescale 1ns/1ps

module fifo_sync_asym import fifo_asym_pkg::*; (
   input  logic                clk,
   input  logic                rst,

   // write side
   input  logic                push,
   input  logic [w_data_w-1:0] push_data,
   output logic                full,

   // read side
   input  logic                pop,
   output logic                empty,
   output logic [r_data_w-1:0] rd_byte,

   output status_t             status
);

   // pointers carry one bit above the address
   logic [w_level_w-1:0] wptr;
   logic [r_level_w-1:0] rptr;

   logic push_en;
   logic pop_en;

   // each pointer scaled to the other side's units
   logic [w_level_w-1:0] rptr_wside;
   logic [r_level_w-1:0] wptr_rside;

   logic [w_level_w-1:0] w_level;
   logic [r_level_w-1:0] r_level;

   assign push_en = push & ~full;
   assign pop_en  = pop & ~empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         wptr <= '0;
      end else if (push_en) begin
         wptr <= wptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rptr <= '0;
      end else if (pop_en) begin
         rptr <= rptr + 1'b1;
      end
   end

   // a partly read word still counts as occupied on the write side
   assign rptr_wside = rptr[r_level_w-1:ratio_log2];
   assign wptr_rside = {wptr, {ratio_log2{1'b0}}};

   assign w_level = wptr - rptr_wside;
   assign r_level = wptr_rside - rptr;

   assign full  = (w_level == w_level_w'(1 << w_addr_w));
   assign empty = (r_level == '0);

   always_comb begin
      status         = '0;
      status.full    = full;
      status.empty   = empty;
      status.r_level = r_level;
      status.w_level = w_level;
   end

   ram_2p_asym u_ram (
      .clk    (clk),
      .w_en   (push_en),
      .w_addr (wptr[w_addr_w-1:0]),
      .w_data (push_data),
      .r_en   (pop_en),
      .r_addr (rptr[r_addr_w-1:0]),
      .r_data (rd_byte)
   );

endmodule

/* design/ram_2p_asym.sv */
`timescale 1ns/1ps

module ram_2p_asym import fifo_asym_pkg::*; (
   input  logic                clk,

   // word wide write port
   input  logic                w_en,
   input  logic [w_addr_w-1:0] w_addr,
   input  logic [w_data_w-1:0] w_data,

   // byte wide read port
   input  logic                r_en,
   input  logic [r_addr_w-1:0] r_addr,
   output logic [r_data_w-1:0] r_data
);

   localparam int depth = 1 << w_addr_w;

   logic [w_data_w-1:0] mem [depth];

   logic [w_addr_w-1:0]   r_word_addr;
   logic [ratio_log2-1:0] r_lane;
   logic [w_data_w-1:0]   r_word;
   logic [r_data_w-1:0]   r_lane_data;

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // upper bits pick the word, lower bits pick the lane
   assign r_word_addr = r_addr[r_addr_w-1:ratio_log2];
   assign r_lane      = r_addr[ratio_log2-1:0];
   assign r_word      = mem[r_word_addr];

   // lane 0 is the least significant byte
   always_comb begin
      r_lane_data = r_word[r_lane*r_data_w +: r_data_w];
   end

   // output register holds its value while r_en is low
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= r_lane_data;
      end
   end

endmodule

/* fifo_asym.f */
design/fifo_asym_pkg.sv
design/ram_2p_asym.sv
design/fifo_sync_asym.sv
design/apb_fifo_regs.sv
design/byte_stream_out.sv
design/fifo_asym_top.sv
test/fifo_asym_checker.sv
test/tb_fifo_asym.sv

/* test/fifo_asym_checker.sv */
`timescale 1ns/1ps

module fifo_asym_checker import fifo_asym_pkg::*; (
   input logic         clk,
   input logic         rst,
   input apb_req_t     apb_req,
   input apb_rsp_t     apb_rsp,
   input byte_stream_t tx,
   input logic         tx_ready
);

   // bytes still owed to the stream, oldest first
   logic [r_data_w-1:0] model_q [$];

   string test_name = "reset";
   int    err_count  = 0;
   int    byte_count = 0;
   int    word_count = 0;

   // response of the most recent access cycle
   logic                last_err;
   logic [w_data_w-1:0] last_rdata;

   // stream byte that was offered but not taken
   logic                hold_q = 1'b0;
   logic [r_data_w-1:0] hold_data;

   always @(posedge clk) begin : monitor
      logic [r_data_w-1:0] exp_byte;
      if (rst) begin
         hold_q = 1'b0;
      end else begin
         // every transfer completes in its first access cycle
         if (apb_req.psel && apb_req.penable && apb_rsp.pready !== 1'b1) begin
            err_count++;
            $display("** Error [%s] pready: expected 1, actual %b",
                     test_name, apb_rsp.pready);
         end
         if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            last_err   = apb_rsp.pslverr;
            last_rdata = apb_rsp.prdata;
            // accepted word, lowest byte leaves first
            if (apb_req.pwrite && apb_req.paddr == reg_data && !apb_rsp.pslverr) begin
               for (int i = 0; i < (1 << ratio_log2); i++) begin
                  model_q.push_back(apb_req.pwdata[i*r_data_w +: r_data_w]);
               end
               word_count++;
            end
         end
         if (hold_q && (tx.valid !== 1'b1 || tx.data !== hold_data)) begin
            err_count++;
            $display("** Error [%s] held byte: expected %h, actual %h",
                     test_name, hold_data, tx.data);
         end
         if (tx.valid && tx_ready) begin
            if (model_q.size() == 0) begin
               err_count++;
               $display("stream sent byte %h in test %s while no byte was queued",
                        tx.data, test_name);
            end else begin
               exp_byte = model_q.pop_front();
               byte_count++;
               if (tx.data !== exp_byte) begin
                  err_count++;
                  $display("** Error [%s] stream byte: expected %h, actual %h",
                           test_name, exp_byte, tx.data);
               end
            end
         end
         hold_q    = tx.valid & ~tx_ready;
         hold_data = tx.data;
      end
   end

   task automatic set_test(input string name);
      test_name = name;
   endtask

   function automatic int pending();
      return model_q.size();
   endfunction

   task automatic check_rsp(input logic exp_err);
      if (last_err !== exp_err) begin
         err_count++;
         $display("** Error [%s] pslverr: expected %0b, actual %0b",
                  test_name, exp_err, last_err);
      end
   endtask

   task automatic check_status(input status_t exp);
      check_rsp(1'b0);
      if (last_rdata !== exp) begin
         err_count++;
         $display("** Error [%s] status: expected %h, actual %h", test_name, exp, last_rdata);
      end
   endtask

   // idle bus and empty stream straight after reset
   task automatic check_idle();
      if (tx.valid !== 1'b0) begin
         err_count++;
         $display("** Error [%s] valid: expected 0, actual %b", test_name, tx.valid);
      end
      if (apb_rsp.pslverr !== 1'b0) begin
         err_count++;
         $display("** Error [%s] pslverr: expected 0, actual %b", test_name, apb_rsp.pslverr);
      end
   endtask

   task automatic check_drained();
      if (model_q.size() != 0) begin
         err_count++;
         $display("** Error [%s] bytes left: expected 0, actual %0d",
                  test_name, model_q.size());
      end
   endtask

endmodule

/* test/tb_fifo_asym.sv */
`timescale 1ns/1ps

module tb_fifo_asym import fifo_asym_pkg::*; ();

   localparam int clk_period     = 100;
   localparam int reset_cycles   = 10;
   localparam int fifo_words     = 1 << w_addr_w;
   localparam int n_rand_words   = 48;
   localparam int n_stall_words  = fifo_words + 4;
   localparam int n_illegal      = 6;
   localparam int n_status_reads = 4;
   localparam int n_xfers        = n_rand_words + n_stall_words + n_illegal + n_status_reads;
   localparam int limit_cycles   = reset_cycles + n_xfers * 20 + 500;

   // a full fifo plus the output stage drains at one byte per cycle
   localparam int drain_cycles   = (fifo_words << ratio_log2) * 4;

   // consumer behaviour
   localparam int ready_random = 0;
   localparam int ready_low    = 1;
   localparam int ready_high   = 2;

   logic         clk;
   logic         rst;
   apb_req_t     apb_req;
   apb_rsp_t     apb_rsp;
   byte_stream_t tx;
   logic         tx_ready;
   int           ready_mode;

   fifo_asym_top UUT (
      .clk      (clk),
      .rst      (rst),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .tx       (tx),
      .tx_ready (tx_ready)
   );

   fifo_asym_checker chk (
      .clk      (clk),
      .rst      (rst),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .tx       (tx),
      .tx_ready (tx_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // ready changes just after each edge
   initial begin
      forever begin
         @(posedge clk);
         #1;
         case (ready_mode)
            ready_random: tx_ready = 1'($urandom % 2);
            ready_low:    tx_ready = 1'b0;
            default:      tx_ready = 1'b1;
         endcase
      end
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", limit_cycles);
      $display("errors: %0d  bytes checked: %0d  words accepted: %0d",
               chk.err_count, chk.byte_count, chk.word_count);
      $display("sim failed");
      $finish;
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // setup cycle, then access cycle, then back to idle
   task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                           input logic [w_data_w-1:0] data);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      next_cycle();
      apb_req.penable = 1'b1;
      next_cycle();
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   // gives up after drain_cycles, missing bytes are then reported
   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (chk.pending() != 0 && cycles < drain_cycles) begin
         next_cycle();
         cycles++;
      end
      next_cycle();
   endtask

   initial begin
      status_t exp_status;
      int      gap;
      void'($urandom(4653));
      rst        = 1'b1;
      apb_req    = '0;
      tx_ready   = 1'b0;
      ready_mode = ready_low;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst = 1'b0;

      chk.set_test("reset");
      next_cycle();
      chk.check_idle();
      apb_xfer(1'b0, reg_status, '0);
      exp_status       = '0;
      exp_status.empty = 1'b1;
      chk.check_status(exp_status);

      chk.set_test("random");
      ready_mode = ready_random;
      for (int i = 0; i < n_rand_words; i++) begin
         gap = $urandom % 4;
         repeat (gap) next_cycle();
         apb_xfer(1'b1, reg_data, $urandom);
      end
      ready_mode = ready_high;
      wait_drained();
      chk.check_drained();

      // consumer stalled, the fifo fills and overflow is refused
      chk.set_test("stall");
      ready_mode = ready_low;
      next_cycle();
      for (int i = 0; i < n_stall_words; i++) begin
         apb_xfer(1'b1, reg_data, $urandom);
         chk.check_rsp(i >= fifo_words);
      end
      repeat (4) next_cycle();
      apb_xfer(1'b0, reg_status, '0);
      exp_status         = '0;
      exp_status.full    = 1'b1;
      exp_status.w_level = w_level_w'(fifo_words);
      exp_status.r_level = r_level_w'((fifo_words << ratio_log2) - 2);
      chk.check_status(exp_status);

      chk.set_test("drain");
      ready_mode = ready_high;
      wait_drained();
      apb_xfer(1'b0, reg_status, '0);
      exp_status       = '0;
      exp_status.empty = 1'b1;
      chk.check_status(exp_status);
      chk.check_drained();

      chk.set_test("illegal");
      apb_xfer(1'b0, reg_data, '0);
      chk.check_rsp(1'b1);
      apb_xfer(1'b1, reg_status, $urandom);
      chk.check_rsp(1'b1);
      apb_xfer(1'b0, 8'h08, '0);
      chk.check_rsp(1'b1);
      apb_xfer(1'b1, 8'h08, $urandom);
      chk.check_rsp(1'b1);
      apb_xfer(1'b1, 8'hfc, $urandom);
      chk.check_rsp(1'b1);
      apb_xfer(1'b0, 8'h01, '0);
      chk.check_rsp(1'b1);
      // stray bytes would show up on the stream here
      repeat (8) next_cycle();
      apb_xfer(1'b0, reg_status, '0);
      chk.check_status(exp_status);

      $display("errors: %0d  bytes checked: %0d  words accepted: %0d",
               chk.err_count, chk.byte_count, chk.word_count);
      if (chk.err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
